//--- hdl/sha_pkg.sv
// SHA-256 package with round constants, initial hash value, word types and round functions.
package sha_pkg;

	typedef logic [31:0] word_t;
	// Element 7 is H0, so the packed vector reads big-endian.
	typedef logic [7:0][31:0] digest_t;

	localparam int ROUNDS = 64;

	localparam logic [0:63][31:0] K = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam digest_t IV = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	function automatic word_t rotr(input word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t big_sigma0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t small_sigma0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic word_t ch(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t maj(input word_t x, input word_t y, input word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage

//--- hdl/miner_pkg.sv
// Miner package with controller states, pass selection and header sizes.
package miner_pkg;

	localparam int HDR_WORDS = 19; // Nonce sits at word 19.
	localparam int ZBITS_W = 9;    // Target range 0 to 256.

	typedef enum logic [3:0] {
		idle,
		init_load1, calc_hash1, out_load1,
		init_load2, calc_hash2, out_load2,
		init_load3, calc_hash3, out_load3,
		hash_check,
		increment,
		hold_hash
	} state_t;

	// Block source for each of the three passes.
	typedef enum logic [1:0] {pass_hdr0, pass_hdr1, pass_digest} pass_t;

endpackage

//--- hdl/hash_controller.sv
// Hash controller FSM that sequences the three SHA passes, nonce increment and hold.
module hash_controller (
	input  logic              clk,
	input  logic              n_rst,
	input  logic              begin_hash,
	input  logic              quit_hash,
	input  logic              hash_rollover,
	input  logic              valid_hash_flag,
	output logic              load_nonce,
	output logic              init,
	output logic              clear,
	output logic              cnt_up,
	output logic              out_load,
	output logic              increment,
	output logic              busy,
	output logic              hash_done,
	output miner_pkg::pass_t  pass_sel
);

	miner_pkg::state_t state;
	miner_pkg::state_t next_state;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= miner_pkg::idle;
		else
			state <= next_state;
	end

	// ##############################
	// Next state and output decode
	// ##############################
	always_comb begin
		next_state = state;
		load_nonce = 1'b0;
		init       = 1'b0;
		clear      = 1'b0;
		cnt_up     = 1'b0;
		out_load   = 1'b0;
		increment  = 1'b0;
		hash_done  = 1'b0;
		pass_sel   = miner_pkg::pass_hdr0;

		case (state)
			miner_pkg::idle: begin
				if (begin_hash) begin
					load_nonce = 1'b1;
					next_state = miner_pkg::init_load1;
				end
			end
			// Pass 1, header block 0 from IV.
			miner_pkg::init_load1: begin
				init       = 1'b1;
				clear      = 1'b1;
				next_state = miner_pkg::calc_hash1;
			end
			miner_pkg::calc_hash1: begin
				cnt_up = 1'b1;
				if (hash_rollover)
					next_state = miner_pkg::out_load1;
			end
			miner_pkg::out_load1: begin
				out_load   = 1'b1;
				next_state = miner_pkg::init_load2;
			end
			// Pass 2 chains on pass 1.
			miner_pkg::init_load2: begin
				init       = 1'b1;
				pass_sel   = miner_pkg::pass_hdr1;
				next_state = miner_pkg::calc_hash2;
			end
			miner_pkg::calc_hash2: begin
				cnt_up   = 1'b1;
				pass_sel = miner_pkg::pass_hdr1;
				if (hash_rollover)
					next_state = miner_pkg::out_load2;
			end
			miner_pkg::out_load2: begin
				out_load   = 1'b1;
				pass_sel   = miner_pkg::pass_hdr1;
				next_state = miner_pkg::init_load3;
			end
			// Pass 3 hashes the first digest.
			miner_pkg::init_load3: begin
				init       = 1'b1;
				clear      = 1'b1;
				pass_sel   = miner_pkg::pass_digest;
				next_state = miner_pkg::calc_hash3;
			end
			miner_pkg::calc_hash3: begin
				cnt_up   = 1'b1;
				pass_sel = miner_pkg::pass_digest;
				if (hash_rollover)
					next_state = miner_pkg::out_load3;
			end
			miner_pkg::out_load3: begin
				out_load   = 1'b1; // Checker captures here.
				pass_sel   = miner_pkg::pass_digest;
				next_state = miner_pkg::hash_check;
			end
			miner_pkg::hash_check: begin
				pass_sel = miner_pkg::pass_digest;
				if (valid_hash_flag)
					next_state = miner_pkg::hold_hash;
				else
					next_state = miner_pkg::increment;
			end
			miner_pkg::increment: begin
				increment  = 1'b1;
				next_state = miner_pkg::init_load1;
			end
			miner_pkg::hold_hash: begin
				hash_done = 1'b1;
				if (begin_hash)
					next_state = miner_pkg::increment; // Resume past this nonce.
			end
			default: next_state = miner_pkg::idle;
		endcase

		if (quit_hash)
			next_state = miner_pkg::idle;
	end

	assign busy = (state != miner_pkg::idle) && (state != miner_pkg::hold_hash);

endmodule

//--- hdl/block_builder.sv
// Block builder holding the header and nonce and assembling the padded block per pass.
module block_builder (
	input  logic               clk,
	input  logic               n_rst,
	input  logic               hdr_we,
	input  logic [4:0]         hdr_addr,
	input  sha_pkg::word_t     hdr_wdata,
	input  sha_pkg::word_t     nonce_start,
	input  logic               load_nonce,
	input  logic               increment,
	input  miner_pkg::pass_t   pass_sel,
	input  sha_pkg::digest_t   chain,
	output sha_pkg::word_t     block [16],
	output sha_pkg::word_t     nonce
);

	sha_pkg::word_t hdr [miner_pkg::HDR_WORDS];

	// Header store.
	always_ff @(posedge clk) begin
		if (hdr_we && (hdr_addr < 5'(miner_pkg::HDR_WORDS)))
			hdr[hdr_addr] <= hdr_wdata;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			nonce <= '0;
		else if (load_nonce)
			nonce <= nonce_start;
		else if (increment)
			nonce <= nonce + 32'd1;
	end

	// ##############################
	// Block assembly
	// ##############################
	always_comb begin
		block = '{default: '0};
		case (pass_sel)
			miner_pkg::pass_hdr0: begin
				for (int i = 0; i < 16; i++)
					block[i] = hdr[i];
			end
			miner_pkg::pass_hdr1: begin
				block[0]  = hdr[16];
				block[1]  = hdr[17];
				block[2]  = hdr[18];
				block[3]  = nonce;
				block[4]  = 32'h8000_0000;
				block[15] = 32'd640; // 80 bytes.
			end
			miner_pkg::pass_digest: begin
				// H0 is the top element of chain.
				for (int i = 0; i < 8; i++)
					block[i] = chain[7 - i];
				block[8]  = 32'h8000_0000;
				block[15] = 32'd256;
			end
			default: block = '{default: '0};
		endcase
	end

endmodule

//--- hdl/sha_round_core.sv
// SHA-256 round core with message schedule, working variables and chaining register.
module sha_round_core (
	input  logic             clk,
	input  logic             n_rst,
	input  logic             init,
	input  logic             clear,
	input  logic             cnt_up,
	input  logic             out_load,
	input  sha_pkg::word_t   block [16],
	output logic             hash_rollover,
	output sha_pkg::digest_t chain
);

	sha_pkg::word_t w [16];
	sha_pkg::word_t a, b, c, d, e, f, g, h;
	sha_pkg::word_t t1, t2, w_next;
	logic [5:0] round_cnt;

	// ##############################
	// Round counter
	// ##############################
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			round_cnt <= '0;
		else if (init)
			round_cnt <= '0;
		else if (cnt_up)
			round_cnt <= round_cnt + 6'd1;
	end

	assign hash_rollover = cnt_up && (round_cnt == 6'(sha_pkg::ROUNDS - 1));

	// ##############################
	// Round datapath
	// ##############################
	always_comb begin
		t1 = h + sha_pkg::big_sigma1(e) + sha_pkg::ch(e, f, g)
			+ sha_pkg::K[round_cnt] + w[0];
		t2 = sha_pkg::big_sigma0(a) + sha_pkg::maj(a, b, c);
		// Word 16 of the sliding window.
		w_next = sha_pkg::small_sigma1(w[14]) + w[9]
			+ sha_pkg::small_sigma0(w[1]) + w[0];
	end

	// Message schedule.
	always_ff @(posedge clk) begin
		if (init) begin
			w <= block;
		end else if (cnt_up) begin
			for (int i = 0; i < 15; i++)
				w[i] <= w[i + 1];
			w[15] <= w_next;
		end
	end

	// Working variables.
	always_ff @(posedge clk) begin
		if (init) begin
			{a, b, c, d, e, f, g, h} <= clear ? sha_pkg::IV : chain;
		end else if (cnt_up) begin
			h <= g;
			g <= f;
			f <= e;
			e <= d + t1;
			d <= c;
			c <= b;
			b <= a;
			a <= t1 + t2;
		end
	end

	// Chaining register, a pairs with chain[7].
	always_ff @(posedge clk) begin
		if (init && clear) begin
			chain <= sha_pkg::IV;
		end else if (out_load) begin
			chain <= {chain[7] + a, chain[6] + b, chain[5] + c, chain[4] + d,
				chain[3] + e, chain[2] + f, chain[1] + g, chain[0] + h};
		end
	end

endmodule

//--- hdl/digest_checker.sv
// Digest checker that captures the final digest and tests its leading zero bits.
module digest_checker (
	input  logic                          clk,
	input  logic                          n_rst,
	input  logic                          out_load,
	input  miner_pkg::pass_t              pass_sel,
	input  sha_pkg::digest_t              chain,
	input  logic [miner_pkg::ZBITS_W-1:0] target_zeros,
	output sha_pkg::digest_t              digest,
	output logic                          valid_hash_flag
);

	logic [255:0] flat;
	logic [miner_pkg::ZBITS_W-1:0] zero_cnt;
	logic found;
	logic capture;

	// Chain carries the final sum one cycle after out_load.
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			capture <= 1'b0;
		else
			capture <= out_load && (pass_sel == miner_pkg::pass_digest);
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			digest <= '0;
		else if (capture)
			digest <= chain; // Second SHA only.
	end

	// Live chain while it is being captured.
	assign flat = capture ? chain : digest;

	// Leading zeros, from H0 downward.
	always_comb begin
		zero_cnt = '0;
		found    = 1'b0;
		for (int i = 255; i >= 0; i--) begin
			if (flat[i])
				found = 1'b1;
			else if (!found)
				zero_cnt = zero_cnt + 1'b1;
		end
	end

	assign valid_hash_flag = (zero_cnt >= target_zeros);

endmodule

//--- hdl/hash_miner.sv
// Hash miner top level joining the controller, block builder, round core and checker.
module hash_miner (
	input  logic                          clk,
	input  logic                          n_rst,
	input  logic                          hdr_we,
	input  logic [4:0]                    hdr_addr,
	input  sha_pkg::word_t                hdr_wdata,
	input  sha_pkg::word_t                nonce_start,
	input  logic [miner_pkg::ZBITS_W-1:0] target_zeros,
	input  logic                          begin_hash,
	input  logic                          quit_hash,
	output logic                          busy,
	output logic                          hash_done,
	output sha_pkg::word_t                nonce,
	output sha_pkg::digest_t              digest
);

	logic load_nonce, init, clear, cnt_up, out_load, increment;
	logic hash_rollover, valid_hash_flag;
	miner_pkg::pass_t pass_sel;
	sha_pkg::digest_t chain;
	sha_pkg::word_t block [16];

	hash_controller u_hash_controller (
		.clk(clk), .n_rst(n_rst),
		.begin_hash(begin_hash), .quit_hash(quit_hash),
		.hash_rollover(hash_rollover), .valid_hash_flag(valid_hash_flag),
		.load_nonce(load_nonce), .init(init), .clear(clear), .cnt_up(cnt_up),
		.out_load(out_load), .increment(increment),
		.busy(busy), .hash_done(hash_done), .pass_sel(pass_sel)
	);

	block_builder u_block_builder (
		.clk(clk), .n_rst(n_rst),
		.hdr_we(hdr_we), .hdr_addr(hdr_addr), .hdr_wdata(hdr_wdata),
		.nonce_start(nonce_start), .load_nonce(load_nonce), .increment(increment),
		.pass_sel(pass_sel), .chain(chain), .block(block), .nonce(nonce)
	);

	sha_round_core u_sha_round_core (
		.clk(clk), .n_rst(n_rst),
		.init(init), .clear(clear), .cnt_up(cnt_up), .out_load(out_load),
		.block(block), .hash_rollover(hash_rollover), .chain(chain)
	);

	digest_checker u_digest_checker (
		.clk(clk), .n_rst(n_rst),
		.out_load(out_load), .pass_sel(pass_sel), .chain(chain),
		.target_zeros(target_zeros), .digest(digest), .valid_hash_flag(valid_hash_flag)
	);

endmodule

//--- tests/sha_model.svh
// SHA-256 reference model with block compression, double hash and leading zero count.
`ifndef SHA_MODEL_SVH
`define SHA_MODEL_SVH

localparam logic [31:0] round_k [64] = '{
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
	32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
	32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
	32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
	32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
	32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

// H0 in the top word.
localparam logic [255:0] init_hash = {
	32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
	32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
};

function automatic logic [31:0] rot_right(input logic [31:0] x, input int n);
	logic [63:0] twice;
	twice = {x, x};
	return twice[n +: 32];
endfunction

function automatic logic [255:0] compress_block(input logic [255:0] hin, input logic [511:0] blk);
	logic [31:0] w [64];
	logic [31:0] v [8];
	logic [31:0] s0, s1, t1, t2;
	logic [255:0] hout;
	for (int i = 0; i < 16; i++)
		w[i] = blk[511 - 32 * i -: 32];
	for (int i = 16; i < 64; i++) begin
		s0 = rot_right(w[i - 15], 7) ^ rot_right(w[i - 15], 18) ^ (w[i - 15] >> 3);
		s1 = rot_right(w[i - 2], 17) ^ rot_right(w[i - 2], 19) ^ (w[i - 2] >> 10);
		w[i] = w[i - 16] + s0 + w[i - 7] + s1;
	end
	for (int i = 0; i < 8; i++)
		v[i] = hin[255 - 32 * i -: 32];
	for (int i = 0; i < 64; i++) begin
		s1 = rot_right(v[4], 6) ^ rot_right(v[4], 11) ^ rot_right(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + round_k[i] + w[i];
		s0 = rot_right(v[0], 2) ^ rot_right(v[0], 13) ^ rot_right(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int j = 7; j > 0; j--)
			v[j] = v[j - 1];
		v[4] = v[4] + t1; // Old d plus t1.
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++)
		hout[255 - 32 * i -: 32] = hin[255 - 32 * i -: 32] + v[i];
	return hout;
endfunction

// Header words 0 to 18 from the top of hdr.
function automatic logic [255:0] double_sha(input logic [607:0] hdr, input logic [31:0] nonce_val);
	logic [255:0] mid;
	logic [255:0] first;
	mid = compress_block(init_hash, hdr[607:96]);
	first = compress_block(mid, {hdr[95:0], nonce_val, 32'h8000_0000, 320'd0, 32'd640});
	return compress_block(init_hash, {first, 32'h8000_0000, 192'd0, 32'd256});
endfunction

function automatic int leading_zeros(input logic [255:0] d);
	int n;
	n = 0;
	while (n < 256 && !d[255 - n])
		n++;
	return n;
endfunction

`endif

//--- tests/tb_hash_miner.sv
// Testbench for the hash miner, a stimulus table checked against a SHA-256 model.
module tb_hash_miner;

	`include "sha_model.svh"

	typedef struct packed {
		logic [31:0] nonce_start;
		logic [8:0]  zeros;
		logic [7:0]  conts;
		logic [15:0] quit_after;
	} row_t;

	localparam int n_rows = 5;
	localparam int max_hits = 3;
	localparam int reset_cycles = 16;
	localparam logic [31:0] restart_step = 32'h40;

	// Nonce start, target zeros, continues, quit cycle.
	localparam row_t rows [n_rows] = '{
		'{32'h0000_1000, 9'd4, 8'd0, 16'd0},
		'{32'h00ab_cd00, 9'd6, 8'd0, 16'd0},
		'{32'h1234_5678, 9'd0, 8'd0, 16'd0},
		'{32'h0000_0100, 9'd4, 8'd2, 16'd0},
		'{32'h0fff_0000, 9'd6, 8'd0, 16'd150}
	};

	logic clk, n_rst, hdr_we, begin_hash, quit_hash;
	logic [4:0] hdr_addr;
	logic [31:0] hdr_wdata, nonce_start;
	logic [8:0] target_zeros;
	logic busy, hash_done;
	sha_pkg::word_t nonce;
	sha_pkg::digest_t digest;

	logic [607:0] hdr_tab [n_rows];
	logic [31:0] exp_nonce [n_rows][max_hits];
	logic [255:0] exp_digest [n_rows][max_hits];
	int exp_k [n_rows][max_hits];
	int cycle_cnt, cycle_limit, check_cnt, err_cnt;

	hash_miner u_hash_miner (
		.clk(clk), .n_rst(n_rst),
		.hdr_we(hdr_we), .hdr_addr(hdr_addr), .hdr_wdata(hdr_wdata),
		.nonce_start(nonce_start), .target_zeros(target_zeros),
		.begin_hash(begin_hash), .quit_hash(quit_hash),
		.busy(busy), .hash_done(hash_done), .nonce(nonce), .digest(digest)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Timeout: the DUT gave no result within %0d cycles", cycle_limit);
			$display("Errors found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		check_cnt++;
		if (got !== exp) begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	// First qualifying nonce at or above start.
	task automatic search_model(input logic [607:0] hdr, input logic [31:0] start,
		input int zeros, output logic [31:0] hit, output logic [255:0] d, output int k);
		k = 1;
		hit = start;
		d = double_sha(hdr, start);
		while (leading_zeros(d) < zeros && k < 65536) begin
			hit = hit + 32'd1;
			k++;
			d = double_sha(hdr, hit);
		end
	endtask

	// Attempt k ends in hold after 199 cycles, plus 200 per failed attempt.
	function automatic int hit_latency(input int k, input bit from_hold);
		return 199 + 200 * (k - 1) + (from_hold ? 1 : 0);
	endfunction

	task automatic write_header(input logic [607:0] hdr);
		for (int i = 0; i < 19; i++) begin
			hdr_we = 1'b1;
			hdr_addr = 5'(i);
			hdr_wdata = hdr[607 - 32 * i -: 32];
			@(posedge clk);
			#1;
		end
		hdr_we = 1'b0;
	endtask

	task automatic pulse_begin();
		begin_hash = 1'b1;
		@(posedge clk);
		#1;
		begin_hash = 1'b0;
	endtask

	task automatic pulse_quit();
		quit_hash = 1'b1;
		@(posedge clk);
		#1;
		quit_hash = 1'b0;
		check_value("busy", 256'(busy), 256'(0));
		check_value("hash_done", 256'(hash_done), 256'(0));
	endtask

	task automatic await_hit(input int r, input int j, input int latency);
		int edges;
		edges = 0;
		while (!hash_done) begin
			@(posedge clk);
			#1;
			edges++;
		end
		check_value("latency", 256'(edges), 256'(latency));
		check_value("nonce", 256'(nonce), 256'(exp_nonce[r][j]));
		check_value("digest", digest, exp_digest[r][j]);
		check_value("busy", 256'(busy), 256'(0));
	endtask

	task automatic report_test(input int n, input string what, input int errs_before);
		$display("test %0d %s: %0d errors", n, what, err_cnt - errs_before);
	endtask

	initial begin
		logic [607:0] hdr_tmp;
		logic [31:0] start, hit;
		logic [255:0] d;
		int k, budget, errs_before;
		clk = 1'b0;
		n_rst = 1'b0;
		hdr_we = 1'b0;
		hdr_addr = '0;
		hdr_wdata = '0;
		nonce_start = '0;
		target_zeros = '0;
		begin_hash = 1'b0;
		quit_hash = 1'b0;
		cycle_cnt = 0;
		cycle_limit = 0;
		check_cnt = 0;
		err_cnt = 0;
		budget = 0;
		void'($urandom(32'h8a36_4bcd));

		// ##############################
		// Expected results
		// ##############################
		for (int r = 0; r < n_rows; r++) begin
			for (int i = 0; i < 19; i++)
				hdr_tmp[607 - 32 * i -: 32] = $urandom;
			hdr_tab[r] = hdr_tmp;
			start = rows[r].nonce_start;
			if (rows[r].quit_after != 0) begin
				start = start + restart_step; // Search after the quit.
				budget = budget + int'(rows[r].quit_after) + 50;
			end
			for (int j = 0; j <= int'(rows[r].conts); j++) begin
				search_model(hdr_tmp, start, int'(rows[r].zeros), hit, d, k);
				exp_nonce[r][j] = hit;
				exp_digest[r][j] = d;
				exp_k[r][j] = k;
				budget = budget + 200 * k + 50;
				start = hit + 32'd1;
			end
		end
		cycle_limit = 2 * budget + reset_cycles;

		repeat (reset_cycles) @(posedge clk);
		#1;
		n_rst = 1'b1;
		errs_before = err_cnt;
		check_value("busy", 256'(busy), 256'(0));
		check_value("hash_done", 256'(hash_done), 256'(0));
		check_value("nonce", 256'(nonce), 256'(0));
		check_value("digest", digest, 256'(0));
		report_test(0, "reset state", errs_before);

		// ##############################
		// Table rows
		// ##############################
		for (int r = 0; r < n_rows; r++) begin
			errs_before = err_cnt;
			write_header(hdr_tab[r]);
			nonce_start = rows[r].nonce_start;
			target_zeros = rows[r].zeros;
			pulse_begin();
			if (rows[r].quit_after != 0) begin
				repeat (int'(rows[r].quit_after) - 1) begin
					@(posedge clk);
					#1;
				end
				check_value("busy", 256'(busy), 256'(1));
				pulse_quit();
				nonce_start = rows[r].nonce_start + restart_step;
				pulse_begin();
			end
			await_hit(r, 0, hit_latency(exp_k[r][0], 1'b0));
			for (int j = 1; j <= int'(rows[r].conts); j++) begin
				pulse_begin(); // Resume from the hold.
				await_hit(r, j, hit_latency(exp_k[r][j], 1'b1));
			end
			pulse_quit();
			report_test(r + 1, "search", errs_before);
		end

		$display("%0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+tests
hdl/sha_pkg.sv
hdl/miner_pkg.sv
hdl/hash_controller.sv
hdl/block_builder.sv
hdl/sha_round_core.sv
hdl/digest_checker.sv
hdl/hash_miner.sv
tests/tb_hash_miner.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_hash_miner -f verilog.f -Mdir obj_dir -o sim_hash_miner
./obj_dir/sim_hash_miner | tee sim.log

if grep -q "^No errors$" sim.log; then
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
